/* src/mainbus_pkg.sv */
package mainbus_pkg;

    // cpu bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;
    localparam int BANK_W = 3;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BANK_W-1:0] bank_t;

    // i/o map
    // tone registers, four bytes per channel
    localparam addr_t SND_BASE  = 16'h0800;

    // one gain byte per channel
    localparam addr_t GAIN_BASE = 16'h0900;

    // bit 0 picks player 1 when set
    localparam addr_t CAB_ADDR  = 16'h0A00;

    // coins and service
    localparam addr_t SYS_ADDR  = 16'h0B00;

    // rom bank, read and write
    localparam addr_t BANK_ADDR = 16'h0C00;

    // dip bank a at +0, bank b at +1
    localparam addr_t DIP_ADDR  = 16'h0D00;

endpackage

/* src/sound_pkg.sv */
package sound_pkg;

    localparam int SAMPLE_W = 16;
    localparam int PERIOD_W = 12;
    localparam int VOLUME_W = 4;
    localparam int GAIN_W   = 8;

    // fractional bits of the 4.4 gain
    localparam int GAIN_FRAC = 4;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [PERIOD_W-1:0]        period_t;
    typedef logic [VOLUME_W-1:0]        volume_t;
    typedef logic [GAIN_W-1:0]          gain_t;
    typedef logic [1:0]                 regsel_t;

    // tone register index within a channel
    localparam regsel_t REG_PER_LO = 2'd0;
    localparam regsel_t REG_PER_HI = 2'd1;
    localparam regsel_t REG_VOL    = 2'd2;
    localparam regsel_t REG_KEY    = 2'd3;

    // 1.0 in 4.4
    localparam gain_t GAIN_UNITY = 8'h10;

endpackage

/* src/apb_bus_decoder.sv */
`timescale 1ns/10ps

module apb_bus_decoder #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    // apb slave
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  mainbus_pkg::addr_t       paddr,
    input  mainbus_pkg::data_t       pwdata,
    output mainbus_pkg::data_t       prdata,
    output logic                     pready,
    output logic                     pslverr,
    // cabinet
    input  logic [1:0]               start_button,
    input  logic [1:0]               coin_input,
    input  logic [5:0]               joystick1,
    input  logic [5:0]               joystick2,
    input  logic                     service,
    input  mainbus_pkg::data_t       dipsw_a,
    input  mainbus_pkg::data_t       dipsw_b,
    // rom bank
    output mainbus_pkg::bank_t       rom_bank,
    // tone channels
    output logic [NUM_CHANNELS-1:0]  chan_we,
    output sound_pkg::regsel_t       snd_reg,
    output mainbus_pkg::data_t       snd_wdata,
    // mixer gains
    output logic [NUM_CHANNELS-1:0]  gain_we,
    output mainbus_pkg::data_t       gain_wdata
);
    import mainbus_pkg::*;

    logic  setup_ph;
    logic  access_ph;
    logic  wr_en;
    addr_t snd_off;
    addr_t gain_off;
    logic  snd_hit;
    logic  gain_hit;
    logic  cab_hit;
    logic  sys_hit;
    logic  bank_hit;
    logic  dip_hit;
    logic  map_hit;
    data_t cab_byte;
    data_t sys_byte;
    data_t dip_byte;
    data_t rd_mux;

    // player byte as the game reads it
    function automatic data_t cab_format(input logic start, input logic [5:0] joy);
        return {start, 1'b1, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
    endfunction

    // apb phases
    assign setup_ph  = psel && !penable;
    assign access_ph = psel && penable;
    assign wr_en     = access_ph && pwrite;

    // no wait states
    assign pready  = access_ph;
    assign pslverr = access_ph && !map_hit;

    // offsets wrap below the base, so one compare covers both ends
    assign snd_off  = paddr - SND_BASE;
    assign gain_off = paddr - GAIN_BASE;

    assign snd_hit  = snd_off < addr_t'(NUM_CHANNELS * 4);
    assign gain_hit = gain_off < addr_t'(NUM_CHANNELS);
    assign cab_hit  = paddr[15:1] == CAB_ADDR[15:1];
    assign sys_hit  = paddr == SYS_ADDR;
    assign bank_hit = paddr == BANK_ADDR;
    assign dip_hit  = paddr[15:1] == DIP_ADDR[15:1];
    assign map_hit  = snd_hit || gain_hit || cab_hit || sys_hit || bank_hit || dip_hit;

    // write strobes, one per channel
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            chan_we[i] = wr_en && snd_hit && (snd_off[5:2] == 4'(i));
            gain_we[i] = wr_en && gain_hit && (gain_off[3:0] == 4'(i));
        end
    end

    assign snd_reg    = snd_off[1:0];
    assign snd_wdata  = pwdata;
    assign gain_wdata = pwdata;

    // bank register
    always_ff @(posedge clk) begin
        if (rst) begin
            rom_bank <= '0;
        end else if (wr_en && bank_hit) begin
            rom_bank <= pwdata[BANK_W-1:0];
        end
    end

    // input ports
    assign cab_byte = paddr[0] ? cab_format(start_button[0], joystick1)
                               : cab_format(start_button[1], joystick2);
    assign sys_byte = {5'b11111, service, coin_input};
    assign dip_byte = paddr[0] ? dipsw_b : dipsw_a;

    // tone and gain space reads as open bus
    always_comb begin
        if (cab_hit) begin
            rd_mux = cab_byte;
        end else if (sys_hit) begin
            rd_mux = sys_byte;
        end else if (dip_hit) begin
            rd_mux = dip_byte;
        end else if (bank_hit) begin
            rd_mux = data_t'(rom_bank);
        end else begin
            rd_mux = 8'hff;
        end
    end

    // sampled in setup, held through access
    always_ff @(posedge clk) begin
        if (setup_ph) begin
            prdata <= rd_mux;
        end
    end

endmodule

/* src/tone_channel.sv */
`timescale 1ns/10ps

module tone_channel (
    input  logic                clk,
    input  logic                rst,
    input  logic                we,
    input  sound_pkg::regsel_t  reg_sel,
    input  mainbus_pkg::data_t  wdata,
    output sound_pkg::sample_t  sample
);
    import sound_pkg::*;

    period_t period_q;
    volume_t volume_q;
    logic    key_q;
    period_t count_q;
    // low means positive half
    logic    phase_q;
    sample_t amp;

    // register file
    always_ff @(posedge clk) begin
        if (rst) begin
            period_q <= '0;
            volume_q <= '0;
            key_q    <= 1'b0;
        end else if (we) begin
            case (reg_sel)
                REG_PER_LO: period_q[7:0]  <= wdata;
                REG_PER_HI: period_q[11:8] <= wdata[3:0];
                REG_VOL:    volume_q       <= wdata[3:0];
                REG_KEY:    key_q          <= wdata[0];
                default:    ;
            endcase
        end
    end

    // half-period counter, parked at the reload value while keyed off
    // so a key-on always starts a fresh positive half
    always_ff @(posedge clk) begin
        if (rst) begin
            count_q <= '0;
            phase_q <= 1'b0;
        end else if (!key_q) begin
            count_q <= period_q;
            phase_q <= 1'b0;
        end else if (count_q == '0) begin
            count_q <= period_q;
            phase_q <= !phase_q;
        end else begin
            count_q <= count_q - 1'b1;
        end
    end

    // volume times 256
    assign amp = sample_t'({volume_q, 8'h00});

    always_ff @(posedge clk) begin
        if (rst || !key_q) begin
            sample <= '0;
        end else if (phase_q) begin
            sample <= -amp;
        end else begin
            sample <= amp;
        end
    end

endmodule

/* src/channel_mixer.sv */
`timescale 1ns/10ps

module channel_mixer #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [NUM_CHANNELS-1:0]               gain_we,
    input  mainbus_pkg::data_t                    gain_wdata,
    input  sound_pkg::sample_t [NUM_CHANNELS-1:0] chan_sample,
    output sound_pkg::sample_t                    snd
);
    import sound_pkg::*;

    // signed product plus room for the channel sum
    localparam int ACC_W = SAMPLE_W + GAIN_W + 1 + $clog2(NUM_CHANNELS + 1);

    typedef logic signed [ACC_W-1:0] acc_t;

    localparam acc_t SAT_MAX = acc_t'(2 ** (SAMPLE_W - 1) - 1);
    localparam acc_t SAT_MIN = acc_t'(-(2 ** (SAMPLE_W - 1)));

    gain_t gain_q [NUM_CHANNELS];
    acc_t  acc_sum;
    acc_t  acc_shift;

    // gain registers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                gain_q[i] <= GAIN_UNITY;
            end
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (gain_we[i]) begin
                    gain_q[i] <= gain_wdata;
                end
            end
        end
    end

    // weighted sum, gain taken as unsigned
    always_comb begin
        acc_t prod;

        acc_sum = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            prod    = $signed(chan_sample[i]) * $signed({1'b0, gain_q[i]});
            acc_sum = acc_sum + prod;
        end
        // drop the 4.4 fraction
        acc_shift = acc_sum >>> GAIN_FRAC;
    end

    // clip to the sample range
    always_ff @(posedge clk) begin
        if (rst) begin
            snd <= '0;
        end else if (acc_shift > SAT_MAX) begin
            snd <= SAT_MAX[SAMPLE_W-1:0];
        end else if (acc_shift < SAT_MIN) begin
            snd <= SAT_MIN[SAMPLE_W-1:0];
        end else begin
            snd <= acc_shift[SAMPLE_W-1:0];
        end
    end

endmodule

/* src/mainbus_top.sv */
`timescale 1ns/10ps

module mainbus_top #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                clk,
    input  logic                rst,
    // apb slave port
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  mainbus_pkg::addr_t  paddr,
    input  mainbus_pkg::data_t  pwdata,
    output mainbus_pkg::data_t  prdata,
    output logic                pready,
    output logic                pslverr,
    // cabinet i/o
    input  logic [1:0]          start_button,
    input  logic [1:0]          coin_input,
    input  logic [5:0]          joystick1,
    input  logic [5:0]          joystick2,
    input  logic                service,
    input  mainbus_pkg::data_t  dipsw_a,
    input  mainbus_pkg::data_t  dipsw_b,
    // board outputs
    output mainbus_pkg::bank_t  rom_bank,
    output sound_pkg::sample_t  snd
);
    import mainbus_pkg::*;
    import sound_pkg::*;

    logic [NUM_CHANNELS-1:0]    chan_we;
    regsel_t                    snd_reg;
    data_t                      snd_wdata;
    logic [NUM_CHANNELS-1:0]    gain_we;
    data_t                      gain_wdata;
    sample_t [NUM_CHANNELS-1:0] chan_sample;

    apb_bus_decoder #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) i_apb_bus_decoder (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .rom_bank     (rom_bank),
        .chan_we      (chan_we),
        .snd_reg      (snd_reg),
        .snd_wdata    (snd_wdata),
        .gain_we      (gain_we),
        .gain_wdata   (gain_wdata)
    );

    // square-wave voices in place of the fm chips
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_chan
        tone_channel i_tone_channel (
            .clk     (clk),
            .rst     (rst),
            .we      (chan_we[i]),
            .reg_sel (snd_reg),
            .wdata   (snd_wdata),
            .sample  (chan_sample[i])
        );
    end

    channel_mixer #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) i_channel_mixer (
        .clk         (clk),
        .rst         (rst),
        .gain_we     (gain_we),
        .gain_wdata  (gain_wdata),
        .chan_sample (chan_sample),
        .snd         (snd)
    );

endmodule

/* verification/mainbus_tb.sv */
`timescale 1ns/10ps

module mainbus_tb;
    import mainbus_pkg::*;
    import sound_pkg::*;

    localparam int NUM_CHANNELS = 4;
    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    // tone tests take a few hundred cycles and bus tests far fewer
    localparam int TIMEOUT_CYCLES = 20000;

    logic    clk;
    logic    rst;
    logic    psel;
    logic    penable;
    logic    pwrite;
    addr_t   paddr;
    data_t   pwdata;
    data_t   prdata;
    logic    pready;
    logic    pslverr;
    logic [1:0] start_button;
    logic [1:0] coin_input;
    logic [5:0] joystick1;
    logic [5:0] joystick2;
    logic    service;
    data_t   dipsw_a;
    data_t   dipsw_b;
    bank_t   rom_bank;
    sample_t snd;

    int test_errs;
    int total_errs;
    int tests_run;
    int tests_failed;
    int cycle_count;

    mainbus_top #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) i_mainbus_top (
        .clk          (clk),
        .rst          (rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .start_button (start_button),
        .coin_input   (coin_input),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .rom_bank     (rom_bank),
        .snd          (snd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s = 0x%0h, expected 0x%0h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // setup cycle and access cycle then back to idle
    task automatic apb_transfer(input addr_t addr, input logic write, input data_t wdata,
                                output data_t rdata, output logic err);
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #DRIVE_DELAY;
        penable = 1'b1;
        @(negedge clk);
        compare_value("pready", pready, 1'b1);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #DRIVE_DELAY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input addr_t addr, input data_t wdata, output logic err);
        data_t unused;

        apb_transfer(addr, 1'b1, wdata, unused, err);
    endtask

    task automatic apb_read(input addr_t addr, output data_t rdata, output logic err);
        apb_transfer(addr, 1'b0, 8'h00, rdata, err);
    endtask

    task automatic read_expect(input addr_t addr, input data_t exp);
        data_t rd;
        logic  err;

        apb_read(addr, rd, err);
        compare_value("prdata", rd, exp);
        compare_value("pslverr", err, 1'b0);
    endtask

    task automatic tone_write(input int ch, input regsel_t sel, input data_t wdata);
        logic err;

        apb_write(SND_BASE + addr_t'(ch * 4) + addr_t'(sel), wdata, err);
        compare_value("pslverr", err, 1'b0);
    endtask

    task automatic gain_write(input int ch, input data_t wdata);
        logic err;

        apb_write(GAIN_BASE + addr_t'(ch), wdata, err);
        compare_value("pslverr", err, 1'b0);
    endtask

    task automatic check_unmapped(input addr_t addr);
        data_t rd;
        logic  err;

        apb_write(addr, 8'h5a, err);
        assert (err === 1'b1) else begin
            $display("[FAIL] pslverr = 0x%0h, expected 0x1 on write to 0x%04h", err, addr);
            test_errs++;
        end
        apb_read(addr, rd, err);
        assert (err === 1'b1) else begin
            $display("[FAIL] pslverr = 0x%0h, expected 0x1 on read of 0x%04h", err, addr);
            test_errs++;
        end
    endtask

    // player byte with the msb first
    function automatic data_t expected_cab(input logic start, input logic [5:0] joy);
        data_t b;

        b[7] = start;
        b[6] = 1'b1;
        b[5] = joy[5];
        b[4] = joy[4];
        b[3] = joy[2];
        b[2] = joy[3];
        b[1] = joy[0];
        b[0] = joy[1];
        return b;
    endfunction

    // volume * 256 * gain in 4.4
    function automatic int scaled_level(input int vol, input int gain);
        return (vol * 256 * gain) / 16;
    endfunction

    // waits for the first sample then checks levels and half-period lengths
    task automatic watch_square(input sample_t pos, input sample_t neg, input int half,
                                input int cycles);
        int      waited;
        int      run_len;
        int      pos_seen;
        int      neg_seen;
        logic    last_neg;
        sample_t s;

        waited   = 0;
        run_len  = 0;
        pos_seen = 0;
        neg_seen = 0;
        @(negedge clk);
        while (snd == 0 && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        assert (snd != 0) else begin
            $display("snd never left zero after key on");
            test_errs++;
        end
        // a fresh key-on starts with the positive half
        compare_value("snd", snd, pos);
        last_neg = snd < 0;
        for (int c = 0; c < cycles; c++) begin
            s = snd;
            assert (s == pos || s == neg) else begin
                $display("[FAIL] snd = 0x%04h, expected 0x%04h or 0x%04h", s, pos, neg);
                test_errs++;
            end
            if (s < 0) begin
                neg_seen++;
            end else begin
                pos_seen++;
            end
            if ((s < 0) != last_neg) begin
                compare_value("half_period", run_len, half);
                run_len  = 0;
                last_neg = s < 0;
            end
            run_len++;
            @(negedge clk);
        end
        assert (pos_seen > 0 && neg_seen > 0) else begin
            $display("snd did not show both signs within %0d cycles", cycles);
            test_errs++;
        end
    endtask

    task automatic wait_silence();
        int waited;

        waited = 0;
        while (snd != 0 && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        repeat (20) begin
            compare_value("snd", snd, 32'h0);
            @(negedge clk);
        end
    endtask

    task automatic test_reset_state();
        compare_value("snd", snd, 32'h0);
        compare_value("rom_bank", rom_bank, 32'h0);
        compare_value("pready", pready, 1'b0);
        compare_value("pslverr", pslverr, 1'b0);
        read_expect(BANK_ADDR, 8'h00);
        finish_test("reset_state");
    endtask

    task automatic test_bank_register();
        bank_t val;
        logic  err;

        for (int i = 0; i < 8; i++) begin
            val = bank_t'($urandom);
            apb_write(BANK_ADDR, data_t'(val), err);
            compare_value("pslverr", err, 1'b0);
            compare_value("rom_bank", rom_bank, val);
            read_expect(BANK_ADDR, data_t'(val));
        end
        check_unmapped(16'h0000);
        check_unmapped(SND_BASE + addr_t'(NUM_CHANNELS * 4));
        check_unmapped(GAIN_BASE + addr_t'(NUM_CHANNELS));
        check_unmapped(SYS_ADDR + 16'h1);
        check_unmapped(BANK_ADDR + 16'h1);
        check_unmapped(DIP_ADDR + 16'h2);
        check_unmapped(16'hffff);
        // stray writes leave the bank alone
        compare_value("rom_bank", rom_bank, val);
        finish_test("bank_register");
    endtask

    task automatic test_input_ports();
        repeat (4) begin
            @(posedge clk);
            #DRIVE_DELAY;
            joystick1    = 6'($urandom);
            joystick2    = 6'($urandom);
            start_button = 2'($urandom);
            coin_input   = 2'($urandom);
            service      = 1'($urandom);
            dipsw_a      = 8'($urandom);
            dipsw_b      = 8'($urandom);
            read_expect(CAB_ADDR + 16'h1, expected_cab(start_button[0], joystick1));
            read_expect(CAB_ADDR, expected_cab(start_button[1], joystick2));
            read_expect(SYS_ADDR, {5'b11111, service, coin_input});
            read_expect(DIP_ADDR, dipsw_a);
            read_expect(DIP_ADDR + 16'h1, dipsw_b);
        end
        finish_test("input_ports");
    endtask

    // relies on the reset gain of channel 0 being 1.0
    task automatic test_single_tone();
        int lvl;

        lvl = scaled_level(5, 8'h10);
        tone_write(0, REG_PER_LO, 8'd20);
        tone_write(0, REG_PER_HI, 8'h00);
        tone_write(0, REG_VOL, 8'h05);
        tone_write(0, REG_KEY, 8'h01);
        watch_square(sample_t'(lvl), sample_t'(-lvl), 21, 200);
        tone_write(0, REG_KEY, 8'h00);
        wait_silence();
        finish_test("single_tone");
    endtask

    task automatic test_gain_saturation();
        int lvl;

        lvl = scaled_level(4, 8'h08);
        gain_write(1, 8'h08);
        tone_write(1, REG_PER_LO, 8'd12);
        tone_write(1, REG_PER_HI, 8'h00);
        tone_write(1, REG_VOL, 8'h04);
        tone_write(1, REG_KEY, 8'h01);
        watch_square(sample_t'(lvl), sample_t'(-lvl), 13, 100);
        tone_write(1, REG_KEY, 8'h00);
        wait_silence();

        // full gain at full volume clips both ways
        lvl = scaled_level(15, 8'hff);
        gain_write(1, 8'hff);
        tone_write(1, REG_VOL, 8'h0f);
        tone_write(1, REG_KEY, 8'h01);
        watch_square(sample_t'((lvl > 32767) ? 32767 : lvl),
                     sample_t'((-lvl < -32768) ? -32768 : -lvl), 13, 100);
        tone_write(1, REG_KEY, 8'h00);
        wait_silence();
        finish_test("gain_saturation");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        start_button = '0;
        coin_input   = '0;
        joystick1    = '0;
        joystick2    = '0;
        service      = 1'b0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        void'($urandom(32'hf2ad2bbd));
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_reset_state();
        test_bank_register();
        test_input_ports();
        test_single_tone();
        test_gain_saturation();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
        if (tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
src/mainbus_pkg.sv
src/sound_pkg.sv
src/apb_bus_decoder.sv
src/tone_channel.sv
src/channel_mixer.sv
src/mainbus_top.sv
verification/mainbus_tb.sv

/* Bender.yml */
package:
  name: mainbus

dependencies: {}

sources:
  # packages first, then the modules that import them
  - files:
      - src/mainbus_pkg.sv
      - src/sound_pkg.sv
      - src/apb_bus_decoder.sv
      - src/tone_channel.sv
      - src/channel_mixer.sv
      - src/mainbus_top.sv

  # testbench
  - target: test
    files:
      - verification/mainbus_tb.sv
